// File: load_unit.f
load_unit_pkg.sv
load_buffer.sv
load_req_fsm.sv
load_result_align.sv
load_unit.sv
tb_load_unit.sv

// File: Makefile
SRCS = $(shell cat load_unit.f)

obj_dir/Vtb_load_unit: $(SRCS) load_unit.f
	verilator --binary --timing --top-module tb_load_unit -f load_unit.f

.PHONY: run clean
run: obj_dir/Vtb_load_unit
	@out="$$(./obj_dir/Vtb_load_unit)"; echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir

// File: tb_load_unit.sv
// testbench for the load unit
// clock, reset, cache responder model with memory and grant delays
// directed tests for load kinds, grant delays, store hazard, full buffer, flush
`timescale 1ns/100ps

module tb_load_unit;

  // run limit in cycles for the whole test sequence
  localparam int MAX_CYCLES = 4000;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     flush_i;
  logic                     valid_i;
  load_unit_pkg::addr_t     addr_i;
  load_unit_pkg::be_t       be_i;
  load_unit_pkg::ld_op_e    op_i;
  load_unit_pkg::trans_id_t trans_id_i;
  logic                     ready_o;
  logic [11:0]              page_offset_o;
  logic                     page_offset_matches_i;
  logic                     dcache_req_o;
  logic                     dcache_gnt_i;
  load_unit_pkg::index_t    dcache_index_o;
  load_unit_pkg::be_t       dcache_be_o;
  load_unit_pkg::size_t     dcache_size_o;
  load_unit_pkg::req_id_t   dcache_id_o;
  load_unit_pkg::tag_t      dcache_tag_o;
  logic                     dcache_tag_valid_o;
  logic                     dcache_kill_o;
  logic                     dcache_rvalid_i;
  load_unit_pkg::req_id_t   dcache_rid_i;
  load_unit_pkg::xlen_t     dcache_rdata_i;
  logic                     valid_o;
  load_unit_pkg::trans_id_t trans_id_o;
  load_unit_pkg::xlen_t     result_o;

  // cache model memory with one doubleword per entry
  load_unit_pkg::xlen_t mem [64];

  // loads granted by the cache and not answered yet
  load_unit_pkg::req_id_t   pend_rid [$];
  load_unit_pkg::addr_t     pend_addr[$];
  load_unit_pkg::ld_op_e    pend_op  [$];
  load_unit_pkg::trans_id_t pend_tid [$];

  int     errors;
  int     checks;
  int     cycles;
  integer seed;

  load_unit #(
    .NR_LDBUF(4)
  ) DUT (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .valid_i              (valid_i),
    .addr_i               (addr_i),
    .be_i                 (be_i),
    .op_i                 (op_i),
    .trans_id_i           (trans_id_i),
    .ready_o              (ready_o),
    .page_offset_o        (page_offset_o),
    .page_offset_matches_i(page_offset_matches_i),
    .dcache_req_o         (dcache_req_o),
    .dcache_gnt_i         (dcache_gnt_i),
    .dcache_index_o       (dcache_index_o),
    .dcache_be_o          (dcache_be_o),
    .dcache_size_o        (dcache_size_o),
    .dcache_id_o          (dcache_id_o),
    .dcache_tag_o         (dcache_tag_o),
    .dcache_tag_valid_o   (dcache_tag_valid_o),
    .dcache_kill_o        (dcache_kill_o),
    .dcache_rvalid_i      (dcache_rvalid_i),
    .dcache_rid_i         (dcache_rid_i),
    .dcache_rdata_i       (dcache_rdata_i),
    .valid_o              (valid_o),
    .trans_id_o           (trans_id_o),
    .result_o             (result_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // cycle counter and run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // access width in bytes of a load kind
  function automatic int op_bytes(input load_unit_pkg::ld_op_e op);
    case (op)
      load_unit_pkg::LD: begin
        return 8;
      end
      load_unit_pkg::LW, load_unit_pkg::LWU: begin
        return 4;
      end
      load_unit_pkg::LH, load_unit_pkg::LHU: begin
        return 2;
      end
      default: begin
        return 1;
      end
    endcase
  endfunction

  // bytes at the offset followed by sign or zero fill per load kind
  function automatic load_unit_pkg::xlen_t expected_result(
    input load_unit_pkg::xlen_t dw, input int off, input load_unit_pkg::ld_op_e op);
    int                   nbytes;
    bit                   sgn;
    load_unit_pkg::xlen_t r;
    nbytes = op_bytes(op);
    // LW, LH and LB take the sign of their top byte
    sgn    = op inside {load_unit_pkg::LW, load_unit_pkg::LH, load_unit_pkg::LB};
    r      = '0;
    for (int k = 0; k < nbytes; k++) begin
      r[8*k +: 8] = dw[8*(off+k) +: 8];
    end
    if (sgn && r[8*nbytes-1]) begin
      for (int k = nbytes; k < 8; k++) begin
        r[8*k +: 8] = 8'hff;
      end
    end
    return r;
  endfunction

  // issue one load with optional store match cycles and a grant after gnt_delay cycles
  task automatic issue_load(input load_unit_pkg::addr_t addr, input load_unit_pkg::ld_op_e op,
                            input load_unit_pkg::trans_id_t tid, input int gnt_delay,
                            input int match_cycles);
    int                 waited;
    bit                 taken;
    int                 nbytes;
    load_unit_pkg::be_t be;
    waited = 0;
    taken  = 1'b0;
    nbytes = op_bytes(op);
    // enables cover the accessed bytes only
    be     = load_unit_pkg::be_t'(((1 << nbytes) - 1) << addr[2:0]);
    @(posedge clk_i);
    valid_i    <= 1'b1;
    addr_i     <= addr;
    op_i       <= op;
    trans_id_i <= tid;
    be_i       <= be;
    if (match_cycles > 0) begin
      // grant is offered and must stay unused while the store matches
      page_offset_matches_i <= 1'b1;
      dcache_gnt_i          <= 1'b1;
      repeat (match_cycles) begin
        @(negedge clk_i);
        checks++;
        if (dcache_req_o || ready_o) begin
          errors++;
          $display("** Error at %0t: load went out while a store offset matched", $time);
        end
        @(posedge clk_i);
      end
      page_offset_matches_i <= 1'b0;
    end
    dcache_gnt_i <= (gnt_delay == 0);
    while (!taken) begin
      @(negedge clk_i);
      if (dcache_req_o && dcache_gnt_i) begin
        taken = 1'b1;
        check_value("ready_o", 64'(ready_o), 64'd1);
        check_value("dcache_tag_valid_o", 64'(dcache_tag_valid_o), 64'd0);
        check_value("dcache_index_o", 64'(dcache_index_o), 64'(addr[11:0]));
        check_value("page_offset_o", 64'(page_offset_o), 64'(addr[11:0]));
        check_value("dcache_be_o", 64'(dcache_be_o), 64'(be));
        check_value("dcache_size_o", 64'(dcache_size_o), 64'($clog2(nbytes)));
        pend_rid.push_back(dcache_id_o);
        pend_addr.push_back(addr);
        pend_op.push_back(op);
        pend_tid.push_back(tid);
      end else if (waited > 0) begin
        // request stays up while the grant is withheld
        check_value("dcache_req_o", 64'(dcache_req_o), 64'd1);
      end
      @(posedge clk_i);
      waited++;
      if (taken) begin
        valid_i      <= 1'b0;
        dcache_gnt_i <= 1'b0;
      end else begin
        dcache_gnt_i <= (waited >= gnt_delay);
      end
    end
    // tag cycle right after the grant
    @(negedge clk_i);
    check_value("dcache_tag_valid_o", 64'(dcache_tag_valid_o), 64'd1);
    check_value("dcache_tag_o", 64'(dcache_tag_o), 64'(addr[31:12]));
  endtask

  // answer pending load idx from memory
  task automatic respond(input int idx, input bit expect_valid);
    load_unit_pkg::req_id_t   rid;
    load_unit_pkg::addr_t     addr;
    load_unit_pkg::ld_op_e    op;
    load_unit_pkg::trans_id_t tid;
    load_unit_pkg::xlen_t     dw;
    rid  = pend_rid[idx];
    addr = pend_addr[idx];
    op   = pend_op[idx];
    tid  = pend_tid[idx];
    pend_rid.delete(idx);
    pend_addr.delete(idx);
    pend_op.delete(idx);
    pend_tid.delete(idx);
    dw = mem[addr[8:3]];
    @(posedge clk_i);
    dcache_rvalid_i <= 1'b1;
    dcache_rid_i    <= rid;
    dcache_rdata_i  <= dw;
    @(negedge clk_i);
    if (expect_valid) begin
      check_value("valid_o", 64'(valid_o), 64'd1);
      check_value("trans_id_o", 64'(trans_id_o), 64'(tid));
      check_value("result_o", result_o, expected_result(dw, int'(addr[2:0]), op));
    end else begin
      check_value("valid_o", 64'(valid_o), 64'd0);
    end
    @(posedge clk_i);
    dcache_rvalid_i <= 1'b0;
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic sweep_load_kinds();
    load_unit_pkg::ld_op_e ops [7];
    int                    step;
    int                    n;
    ops = '{load_unit_pkg::LD, load_unit_pkg::LW, load_unit_pkg::LWU, load_unit_pkg::LH,
            load_unit_pkg::LHU, load_unit_pkg::LB, load_unit_pkg::LBU};
    n = 0;
    for (int o = 0; o < 7; o++) begin
      step = op_bytes(ops[o]);
      for (int off = 0; off < 8; off += step) begin
        issue_load(32'h8000_2000 + 32'(n * 8 + off), ops[o], 4'(n), 0, 0);
        respond(0, 1'b1);
        n++;
      end
    end
  endtask

  task automatic delayed_grant_loads();
    int d;
    for (int i = 0; i < 10; i++) begin
      d = $unsigned($random(seed)) % 4;
      issue_load(32'h1234_5000 + 32'(i * 8 + 4), load_unit_pkg::LW, 4'(i + 3), d, 0);
      respond(0, 1'b1);
    end
  endtask

  task automatic store_match_hold();
    issue_load(32'h0040_3108, load_unit_pkg::LH, 4'd9, 0, 5);
    respond(0, 1'b1);
    issue_load(32'h0040_3116, load_unit_pkg::LHU, 4'd10, 2, 3);
    respond(0, 1'b1);
  endtask

  task automatic full_buffer_reverse();
    for (int i = 0; i < 4; i++) begin
      issue_load(32'h9000_0040 + 32'(i * 8), load_unit_pkg::LD, 4'(i + 1), 0, 0);
    end
    // fifth load must wait for a free slot
    @(posedge clk_i);
    valid_i    <= 1'b1;
    addr_i     <= 32'h9000_0060;
    op_i       <= load_unit_pkg::LB;
    trans_id_i <= 4'd5;
    dcache_gnt_i <= 1'b1;
    repeat (6) begin
      @(negedge clk_i);
      check_value("ready_o", 64'(ready_o), 64'd0);
      check_value("dcache_req_o", 64'(dcache_req_o), 64'd0);
    end
    @(posedge clk_i);
    valid_i      <= 1'b0;
    dcache_gnt_i <= 1'b0;
    for (int i = 3; i >= 0; i--) begin
      respond(i, 1'b1);
    end
    issue_load(32'h9000_0063, load_unit_pkg::LB, 4'd5, 1, 0);
    respond(0, 1'b1);
  endtask

  task automatic flush_in_flight();
    bit kill_seen;
    kill_seen = 1'b0;
    issue_load(32'h0070_0100, load_unit_pkg::LW, 4'd11, 0, 0);
    issue_load(32'h0070_0108, load_unit_pkg::LBU, 4'd12, 1, 0);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    repeat (2) begin
      @(negedge clk_i);
      if (dcache_kill_o) begin
        kill_seen = 1'b1;
      end
    end
    checks++;
    if (!kill_seen) begin
      errors++;
      $display("** Error at %0t: no cache kill after the flush", $time);
    end
    // both answers belong to flushed loads
    respond(1, 1'b0);
    respond(0, 1'b0);
    issue_load(32'h0070_0110, load_unit_pkg::LH, 4'd13, 2, 0);
    respond(0, 1'b1);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    errors                = 0;
    checks                = 0;
    cycles                = 0;
    seed                  = 68;
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    addr_i                = '0;
    be_i                  = '0;
    op_i                  = load_unit_pkg::LD;
    trans_id_i            = '0;
    page_offset_matches_i = 1'b0;
    dcache_gnt_i          = 1'b0;
    dcache_rvalid_i       = 1'b0;
    dcache_rid_i          = '0;
    dcache_rdata_i        = '0;
    // byte value follows the full byte address so the msb varies
    for (int i = 0; i < 64; i++) begin
      for (int j = 0; j < 8; j++) begin
        mem[i][8*j +: 8] = 8'((i * 8 + j) * 73 + 17);
      end
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("ready_o", 64'(ready_o), 64'd0);
    check_value("dcache_req_o", 64'(dcache_req_o), 64'd0);
    check_value("dcache_tag_valid_o", 64'(dcache_tag_valid_o), 64'd0);
    check_value("dcache_kill_o", 64'(dcache_kill_o), 64'd0);
    check_value("valid_o", 64'(valid_o), 64'd0);

    sweep_load_kinds();
    delayed_grant_loads();
    store_match_hold();
    full_buffer_reverse();
    flush_in_flight();

    repeat (2) @(posedge clk_i);
    $display("summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: load_unit.sv
// top level of the load unit
// request FSM, outstanding load buffer and result alignment
// address slicing for store check and cache index
`timescale 1ns/100ps

module load_unit #(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  // issue port
  input  logic                     valid_i,
  input  load_unit_pkg::addr_t     addr_i,
  input  load_unit_pkg::be_t       be_i,
  input  load_unit_pkg::ld_op_e    op_i,
  input  load_unit_pkg::trans_id_t trans_id_i,
  output logic                     ready_o,
  // store unit
  output logic [load_unit_pkg::PAGE_OFFSET_W-1:0] page_offset_o,
  input  logic                     page_offset_matches_i,
  // cache request
  output logic                     dcache_req_o,
  input  logic                     dcache_gnt_i,
  output load_unit_pkg::index_t    dcache_index_o,
  output load_unit_pkg::be_t       dcache_be_o,
  output load_unit_pkg::size_t     dcache_size_o,
  output load_unit_pkg::req_id_t   dcache_id_o,
  output load_unit_pkg::tag_t      dcache_tag_o,
  output logic                     dcache_tag_valid_o,
  output logic                     dcache_kill_o,
  // cache response
  input  logic                     dcache_rvalid_i,
  input  load_unit_pkg::req_id_t   dcache_rid_i,
  input  load_unit_pkg::xlen_t     dcache_rdata_i,
  // writeback
  output logic                     valid_o,
  output load_unit_pkg::trans_id_t trans_id_o,
  output load_unit_pkg::xlen_t     result_o
);

  logic                   ldbuf_w;
  logic                   ldbuf_full;
  load_unit_pkg::offset_t rd_offset;
  load_unit_pkg::ld_op_e  rd_op;

  // low address bits go straight to the store check and the cache index
  assign page_offset_o  = addr_i[load_unit_pkg::PAGE_OFFSET_W-1:0];
  assign dcache_index_o = addr_i[load_unit_pkg::INDEX_W-1:0];
  assign dcache_be_o    = be_i;

  load_req_fsm u_req_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .valid_i              (valid_i),
    .addr_i               (addr_i),
    .op_i                 (op_i),
    .ready_o              (ready_o),
    .page_offset_matches_i(page_offset_matches_i),
    .ldbuf_full_i         (ldbuf_full),
    .ldbuf_w_o            (ldbuf_w),
    .dcache_gnt_i         (dcache_gnt_i),
    .dcache_req_o         (dcache_req_o),
    .dcache_size_o        (dcache_size_o),
    .dcache_tag_o         (dcache_tag_o),
    .dcache_tag_valid_o   (dcache_tag_valid_o),
    .dcache_kill_o        (dcache_kill_o)
  );

  // request id sent to the cache is the claimed buffer slot
  load_buffer #(
    .NR_LDBUF(NR_LDBUF)
  ) u_load_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .ldbuf_w_i   (ldbuf_w),
    .trans_id_i  (trans_id_i),
    .offset_i    (addr_i[load_unit_pkg::OFFSET_W-1:0]),
    .op_i        (op_i),
    .rvalid_i    (dcache_rvalid_i),
    .rid_i       (dcache_rid_i),
    .full_o      (ldbuf_full),
    .free_id_o   (dcache_id_o),
    .resp_valid_o(valid_o),
    .trans_id_o  (trans_id_o),
    .offset_o    (rd_offset),
    .op_o        (rd_op)
  );

  load_result_align u_result_align (
    .rdata_i (dcache_rdata_i),
    .op_i    (rd_op),
    .offset_i(rd_offset),
    .result_o(result_o)
  );

endmodule

// File: load_result_align.sv
// realignment of the returned doubleword
// shift by the byte offset, sign or zero extension per load kind
`timescale 1ns/100ps

module load_result_align (
  input  load_unit_pkg::xlen_t   rdata_i,
  input  load_unit_pkg::ld_op_e  op_i,
  input  load_unit_pkg::offset_t offset_i,
  output load_unit_pkg::xlen_t   result_o
);

  load_unit_pkg::xlen_t   shifted_data;
  // msb of every byte lane
  logic [7:0]             sign_bits;
  // lane holding the sign of the loaded value
  load_unit_pkg::offset_t sign_offset;
  logic                   is_signed;
  logic                   sign_bit;

  // bring the addressed byte down to lane 0
  assign shifted_data = rdata_i >> {offset_i, 3'b000};

  for (genvar i = 0; i < 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[8*i+7];
  end

  // sign lane is picked from the raw data, in parallel with the shifter
  assign is_signed   = op_i inside {load_unit_pkg::LW, load_unit_pkg::LH, load_unit_pkg::LB};
  assign sign_offset = (op_i == load_unit_pkg::LW) ? offset_i + 3'd3 :
                       (op_i == load_unit_pkg::LH) ? offset_i + 3'd1 :
                                                     offset_i;
  // unsigned loads pull the fill to zero
  assign sign_bit    = is_signed && sign_bits[sign_offset];

  // ----------------------------------------
  // result mux
  // ----------------------------------------
  always_comb begin : result_mux
    case (op_i)
      load_unit_pkg::LW, load_unit_pkg::LWU: begin
        result_o = {{32{sign_bit}}, shifted_data[31:0]};
      end
      load_unit_pkg::LH, load_unit_pkg::LHU: begin
        result_o = {{48{sign_bit}}, shifted_data[15:0]};
      end
      load_unit_pkg::LB, load_unit_pkg::LBU: begin
        result_o = {{56{sign_bit}}, shifted_data[7:0]};
      end
      // LD and unused codes pass the shifted word
      default: begin
        result_o = shifted_data;
      end
    endcase
  end

endmodule

// File: load_req_fsm.sv
// request side of the load unit
// issue handshake, store offset hazard wait, cache grant wait
// tag cycle and kill on flush
`timescale 1ns/100ps

module load_req_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  // issue port
  input  logic                  valid_i,
  input  load_unit_pkg::addr_t  addr_i,
  input  load_unit_pkg::ld_op_e op_i,
  output logic                  ready_o,
  // store unit hazard check
  input  logic                  page_offset_matches_i,
  // load buffer
  input  logic                  ldbuf_full_i,
  output logic                  ldbuf_w_o,
  // cache request
  input  logic                  dcache_gnt_i,
  output logic                  dcache_req_o,
  output load_unit_pkg::size_t  dcache_size_o,
  output load_unit_pkg::tag_t   dcache_tag_o,
  output logic                  dcache_tag_valid_o,
  output logic                  dcache_kill_o
);

  load_unit_pkg::ld_state_e state_q, state_d;
  load_unit_pkg::tag_t      tag_q;

  // request may start only with room left in the buffer
  logic req_ok;
  // cache took the index this cycle
  logic req_taken;

  assign req_ok    = valid_i && !ldbuf_full_i;
  assign req_taken = dcache_req_o && dcache_gnt_i;

  // size code follows the load kind
  assign dcache_size_o = load_unit_pkg::transfer_size(op_i);

  // ----------------------------------------
  // next state and request control
  // ----------------------------------------
  always_comb begin : fsm_comb
    state_d            = state_q;
    dcache_req_o       = 1'b0;
    dcache_tag_valid_o = 1'b0;
    dcache_kill_o      = 1'b0;

    case (state_q)
      // SEND_TAG finishes the previous load and can start the next one
      load_unit_pkg::IDLE,
      load_unit_pkg::SEND_TAG: begin
        if (state_q == load_unit_pkg::SEND_TAG) begin
          dcache_tag_valid_o = 1'b1;
          // tag going out belongs to a load that is being flushed
          dcache_kill_o      = flush_i;
          state_d            = load_unit_pkg::IDLE;
        end
        if (req_ok) begin
          if (!page_offset_matches_i) begin
            // index goes out now, tag follows after the grant
            dcache_req_o = 1'b1;
            if (dcache_gnt_i) begin
              state_d = load_unit_pkg::SEND_TAG;
            end else begin
              state_d = load_unit_pkg::WAIT_GNT;
            end
          end else begin
            // pending store to the same offset, hold the load back
            state_d = load_unit_pkg::WAIT_PAGE_OFFSET;
          end
        end
      end

      load_unit_pkg::WAIT_GNT: begin
        // keep the request up until the cache grants
        dcache_req_o = 1'b1;
        if (dcache_gnt_i) begin
          state_d = load_unit_pkg::SEND_TAG;
        end
      end

      load_unit_pkg::WAIT_PAGE_OFFSET: begin
        // store has drained, retry
        if (!page_offset_matches_i) begin
          state_d = load_unit_pkg::WAIT_GNT;
        end
      end

      load_unit_pkg::WAIT_FLUSH: begin
        // cancel whatever index the cache may still hold
        dcache_kill_o      = 1'b1;
        dcache_tag_valid_o = 1'b1;
        state_d            = load_unit_pkg::IDLE;
      end

      default: begin
        state_d = load_unit_pkg::IDLE;
      end
    endcase

    // flush overrides every transition
    if (flush_i) begin
      state_d = load_unit_pkg::WAIT_FLUSH;
    end
  end

  // pop the issue port and claim a buffer slot on the grant
  assign ready_o   = req_taken;
  assign ldbuf_w_o = req_taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= load_unit_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // tag cycle
  // ----------------------------------------
  // physical address is the request address, upper bits go out one cycle later
  always_ff @(posedge clk_i) begin
    if (req_taken) begin
      tag_q <= addr_i[load_unit_pkg::ADDR_W-1:load_unit_pkg::INDEX_W];
    end
  end

  assign dcache_tag_o = tag_q;

endmodule

// File: load_buffer.sv
// table of outstanding loads, indexed by the cache request id
// lowest free slot search, flush marking of in-flight entries
// combinational lookup of the record that belongs to a response
`timescale 1ns/100ps

module load_buffer #(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     ldbuf_w_i,
  input  load_unit_pkg::trans_id_t trans_id_i,
  input  load_unit_pkg::offset_t   offset_i,
  input  load_unit_pkg::ld_op_e    op_i,
  input  logic                     rvalid_i,
  input  load_unit_pkg::req_id_t   rid_i,
  output logic                     full_o,
  output load_unit_pkg::req_id_t   free_id_o,
  output logic                     resp_valid_o,
  output load_unit_pkg::trans_id_t trans_id_o,
  output load_unit_pkg::offset_t   offset_o,
  output load_unit_pkg::ld_op_e    op_o
);

  // slot state
  logic [NR_LDBUF-1:0] valid_q, valid_d;
  logic [NR_LDBUF-1:0] flushed_q, flushed_d;
  // per slot record
  load_unit_pkg::trans_id_t trans_id_q [NR_LDBUF];
  load_unit_pkg::offset_t   offset_q   [NR_LDBUF];
  load_unit_pkg::ld_op_e    op_q       [NR_LDBUF];

  // one-hot slot selects
  logic [NR_LDBUF-1:0] wr_hot;
  logic [NR_LDBUF-1:0] rid_hot;

  assign full_o = &valid_q;

  // lowest free slot, scanned from the top so the lowest index wins
  always_comb begin : free_search
    free_id_o = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id_o = load_unit_pkg::req_id_t'(i);
      end
    end
  end

  for (genvar i = 0; i < NR_LDBUF; i++) begin : gen_slot_sel
    assign wr_hot[i]  = ldbuf_w_i && (free_id_o == load_unit_pkg::req_id_t'(i));
    assign rid_hot[i] = (rid_i == load_unit_pkg::req_id_t'(i));
  end

  // ----------------------------------------
  // slot bookkeeping
  // ----------------------------------------
  // response frees its slot, new load claims one
  assign valid_d   = (valid_q & ~(rid_hot & {NR_LDBUF{rvalid_i}})) | wr_hot;
  // flush wins over the write, a load granted in the flush cycle is dropped too
  assign flushed_d = flush_i ? '1 : (flushed_q & ~wr_hot);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  // record is only written when a slot is taken
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NR_LDBUF; i++) begin
      if (wr_hot[i]) begin
        trans_id_q[i] <= trans_id_i;
        offset_q[i]   <= offset_i;
        op_q[i]       <= op_i;
      end
    end
  end

  // ----------------------------------------
  // response lookup
  // ----------------------------------------
  always_comb begin : read_mux
    trans_id_o = '0;
    offset_o   = '0;
    op_o       = load_unit_pkg::LD;
    for (int i = 0; i < NR_LDBUF; i++) begin
      if (rid_hot[i]) begin
        trans_id_o = trans_id_q[i];
        offset_o   = offset_q[i];
        op_o       = op_q[i];
      end
    end
  end

  // responses to flushed slots retire silently
  assign resp_valid_o = rvalid_i && |(rid_hot & ~flushed_q);

endmodule

// File: load_unit_pkg.sv
// shared definitions for the load unit
// widths, vector typedefs, load operation and FSM state enums
// transfer size encoding for the cache request
package load_unit_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned XLEN          = 64;
  localparam int unsigned ADDR_W        = 32;
  localparam int unsigned PAGE_OFFSET_W = 12;
  localparam int unsigned INDEX_W       = 12;
  // upper address bits go out in the tag cycle
  localparam int unsigned TAG_W         = ADDR_W - INDEX_W;
  localparam int unsigned TRANS_ID_W    = 4;
  localparam int unsigned REQ_ID_W      = 3;
  // byte position inside a doubleword
  localparam int unsigned OFFSET_W      = 3;

  // ----------------------------------------
  // vector types
  // ----------------------------------------
  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [REQ_ID_W-1:0]   req_id_t;
  typedef logic [7:0]            be_t;
  typedef logic [OFFSET_W-1:0]   offset_t;
  typedef logic [1:0]            size_t;

  // load kinds, signed and unsigned variants
  typedef enum logic [2:0] {
    LD  = 3'd0,
    LW  = 3'd1,
    LWU = 3'd2,
    LH  = 3'd3,
    LHU = 3'd4,
    LB  = 3'd5,
    LBU = 3'd6
  } ld_op_e;

  // request side FSM states
  typedef enum logic [2:0] {
    IDLE             = 3'd0,
    WAIT_GNT         = 3'd1,
    SEND_TAG         = 3'd2,
    WAIT_PAGE_OFFSET = 3'd3,
    WAIT_FLUSH       = 3'd4
  } ld_state_e;

  // byte=0, half=1, word=2, double=3
  function automatic size_t transfer_size(ld_op_e op);
    case (op)
      LD:       return 2'd3;
      LW, LWU:  return 2'd2;
      LH, LHU:  return 2'd1;
      default:  return 2'd0;
    endcase
  endfunction

endpackage
